//--- src.f
src/jtag_pkg.sv
src/debug_pkg.sv
src/jtag_sync.sv
src/tap_ctrl.sv
src/dr_scan.sv
src/cfg_regfile.sv
src/debug_top.sv
tb/debug_top_chk.sv
tb/debug_top_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module debug_top_tb -f src.f
./obj_dir/Vdebug_top_tb | tee sim.log
if grep -q "\*\* FAIL \*\*" sim.log; then
	exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
	exit 1
fi
exit 0

//--- tb/debug_top_tb.sv
`timescale 1ns/100ps

module debug_top_tb;
	import jtag_pkg::*;
	import debug_pkg::*;

	localparam int NUM_CFG = 8;
	localparam int NUM_STAT = 2;
	localparam idcode_t IDCODE = 32'h1D4B_0E93;

	logic clk = 1'b0;
	logic rst_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic tdo_o;
	logic [NUM_CFG*DATA_W-1:0] cfg_o;
	logic [NUM_STAT*DATA_W-1:0] status_i;

	reg_data_t cfg_model [NUM_CFG];
	logic [31:0] lcg_state;
	int errors;
	int checks;
	int tests;
	bit aborted;

	debug_top #(
		.NUM_CFG(NUM_CFG),
		.NUM_STAT(NUM_STAT),
		.IDCODE(IDCODE)
	) UUT (
		.clk(clk),
		.rst_i(rst_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tdo_o(tdo_o),
		.cfg_o(cfg_o),
		.status_i(status_i)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	function automatic reg_data_t lcg16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_id(input string name, input idcode_t got, input idcode_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_cfg();
		for (int a = 0; a < NUM_CFG; a++) begin
			check_data($sformatf("cfg_o[%0d]", a), cfg_o[a*DATA_W +: DATA_W], cfg_model[a]);
		end
	endtask

	task automatic wait_state(input tap_state_t want);
		int n;
		n = 0;
		while (UUT.u_tap.state_o != want && n < 64 && !aborted) begin
			@(negedge clk);
			n++;
		end
		if (UUT.u_tap.state_o != want && !aborted) begin
			errors++;
			aborted = 1'b1;
			$display("timeout: TAP never reached %s", want.name());
		end
	endtask

	// One TCK period, 4 clk low then 4 clk high, TDO sampled before the rise
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo_s);
		tdo_s = 1'b0;
		if (aborted) return;
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		repeat (4) @(negedge clk);
		tdo_s = tdo_o;
		tck_i = 1'b1;
		repeat (4) @(negedge clk);
	endtask

	task automatic go_idle();
		logic b;
		tck_cycle(1'b0, 1'b0, b);
		wait_state(TAP_IDLE);
	endtask

	task automatic scan_ir(input ir_t code);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < IR_LEN; i++) begin
			tck_cycle(i == IR_LEN - 1, code[i], b);
			// Captured IR ends in 01
			if (i == 0) check_bit("tdo_o ir[0]", b, 1'b1);
			if (i == 1) check_bit("tdo_o ir[1]", b, 1'b0);
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		wait_state(TAP_IDLE);
	endtask

	task automatic scan_dr(input int len, input logic [31:0] din, output logic [31:0] dout);
		logic b;
		dout = '0;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		wait_state(TAP_IDLE);
	endtask

	task automatic dbg_access(input logic we, input reg_addr_t addr, input reg_data_t data,
			output reg_data_t rd);
		logic [31:0] dout;
		scan_dr(DBG_DR_LEN, {7'b0, data, addr, we}, dout);
		rd = dout[9 +: DATA_W];
	endtask

	// First scan latches the address, second captures its data
	task automatic read_reg(input reg_addr_t addr, output reg_data_t rd);
		reg_data_t dummy;
		dbg_access(1'b0, addr, '0, dummy);
		dbg_access(1'b0, addr, '0, rd);
	endtask

	task automatic check_idcode();
		logic [31:0] dout;
		scan_dr(32, '0, dout);
		check_id("idcode", dout, IDCODE);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
	endtask

	task automatic test_idcode_reset();
		int e;
		e = errors;
		go_idle();
		check_idcode();
		end_test("idcode after reset", e);
	endtask

	task automatic test_bypass();
		int e;
		logic [31:0] din;
		logic [31:0] dout;
		e = errors;
		din = {lcg16(), lcg16()};
		scan_ir(INSTR_BYPASS);
		scan_dr(32, din, dout);
		check_bit("tdo_o bypass[0]", dout[0], 1'b0);
		for (int i = 1; i < 32; i++) check_bit("tdo_o bypass", dout[i], din[i-1]);
		// Undefined code acts as BYPASS
		scan_ir(4'b0110);
		scan_dr(32, din, dout);
		check_bit("tdo_o undef[0]", dout[0], 1'b0);
		for (int i = 1; i < 32; i++) check_bit("tdo_o undef", dout[i], din[i-1]);
		end_test("bypass", e);
	endtask

	task automatic test_cfg_write();
		int e;
		reg_data_t d;
		reg_data_t rd;
		e = errors;
		scan_ir(INSTR_DBG);
		for (int a = 0; a < NUM_CFG; a++) begin
			d = lcg16();
			dbg_access(1'b1, 8'(a), d, rd);
			cfg_model[a] = d;
			check_cfg();
		end
		end_test("config write", e);
	endtask

	task automatic test_readback();
		int e;
		reg_data_t rd;
		reg_data_t stat [NUM_STAT];
		e = errors;
		for (int s = 0; s < NUM_STAT; s++) begin
			stat[s] = lcg16();
			status_i[s*DATA_W +: DATA_W] = stat[s];
		end
		for (int a = 0; a < NUM_CFG; a++) begin
			read_reg(8'(a), rd);
			check_data($sformatf("readback cfg %0d", a), rd, cfg_model[a]);
		end
		for (int s = 0; s < NUM_STAT; s++) begin
			read_reg(STATUS_BASE + 8'(s), rd);
			check_data($sformatf("readback status %0d", s), rd, stat[s]);
		end
		end_test("readback", e);
	endtask

	task automatic test_unmapped();
		int e;
		reg_data_t rd;
		reg_addr_t addrs [4];
		e = errors;
		addrs = '{8'(NUM_CFG), 8'h40, STATUS_BASE + 8'(NUM_STAT), 8'hFF};
		foreach (addrs[i]) begin
			dbg_access(1'b1, addrs[i], lcg16(), rd);
			check_cfg();
			read_reg(addrs[i], rd);
			check_data($sformatf("read of %h", addrs[i]), rd, '0);
		end
		// Status words are read-only
		dbg_access(1'b1, STATUS_BASE, lcg16(), rd);
		check_cfg();
		read_reg(STATUS_BASE, rd);
		check_data("status after write", rd, status_i[0 +: DATA_W]);
		end_test("unmapped and status writes", e);
	endtask

	task automatic test_tap_reset();
		int e;
		logic b;
		e = errors;
		scan_ir(INSTR_BYPASS);
		trst_n_i = 1'b0;
		wait_state(TAP_RESET);
		repeat (2) @(negedge clk);
		trst_n_i = 1'b1;
		repeat (4) @(negedge clk);
		go_idle();
		check_idcode();
		check_cfg();
		scan_ir(INSTR_DBG);
		for (int i = 0; i < 5; i++) tck_cycle(1'b1, 1'b0, b);
		wait_state(TAP_RESET);
		go_idle();
		check_idcode();
		check_cfg();
		end_test("TAP reset", e);
	endtask

	initial begin
		rst_i = 1'b1;
		tck_i = 1'b0;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		status_i = '0;
		lcg_state = 32'd65267;
		errors = 0;
		checks = 0;
		tests = 0;
		aborted = 1'b0;
		for (int a = 0; a < NUM_CFG; a++) cfg_model[a] = '0;
		repeat (3) @(negedge clk);
		rst_i = 1'b0;
		wait_state(TAP_RESET);
		check_cfg();
		check_bit("tdo_o", tdo_o, 1'b0);
		test_idcode_reset();
		test_bypass();
		test_cfg_write();
		test_readback();
		test_unmapped();
		test_tap_reset();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- tb/debug_top_chk.sv
`timescale 1ns/100ps

module debug_top_chk #(
	parameter int VAL_W = 16,
	parameter logic [VAL_W-1:0] RST_VAL = '0
) (
	input logic clk,
	input logic rst_i,
	input logic strobe_i,
	input logic [VAL_W-1:0] val_i
);

	assert property (@(posedge clk) disable iff (rst_i) strobe_i |=> !strobe_i)
		else $error("strobe wider than one clk");

	assert property (@(posedge clk) rst_i |=> val_i == RST_VAL)
		else $error("reset value not reached one clk after rst_i");

endmodule

// TAP state and Update-DR strobe
bind tap_ctrl debug_top_chk #(
	.VAL_W($bits(jtag_pkg::tap_state_t)),
	.RST_VAL(jtag_pkg::TAP_RESET)
) u_chk (
	.clk(clk),
	.rst_i(rst_i),
	.strobe_i(update_dr_o),
	.val_i(state_o)
);

// Write request from Update-DR and the config outputs
bind cfg_regfile debug_top_chk #(
	.VAL_W(NUM_CFG*debug_pkg::DATA_W)
) u_chk (
	.clk(clk),
	.rst_i(rst_i),
	.strobe_i(req_i),
	.val_i(cfg_o)
);

//--- src/debug_top.sv
`timescale 1ns/100ps
`default_nettype none

module debug_top #(
	parameter int NUM_CFG = 8,
	parameter int NUM_STAT = 2,
	parameter jtag_pkg::idcode_t IDCODE = 32'h1D4B_0E93
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tdo_o,
	output logic [NUM_CFG*debug_pkg::DATA_W-1:0] cfg_o,
	input wire logic [NUM_STAT*debug_pkg::DATA_W-1:0] status_i
);
	import jtag_pkg::*;
	import debug_pkg::*;

	logic tck_rise;
	logic tck_fall;
	logic tms_s;
	logic tdi_s;
	logic trst_n_s;

	tap_state_t tap_state;
	ir_t ir;
	logic ir_tdo;
	logic capture_dr;
	logic shift_dr;
	logic update_dr;

	logic req;
	logic we;
	reg_addr_t addr;
	reg_data_t wr_data;
	reg_data_t rd_data;

	jtag_sync u_sync (
		.clk(clk),
		.rst_i(rst_i),
		.tck_i(tck_i),
		.tms_i(tms_i),
		.tdi_i(tdi_i),
		.trst_n_i(trst_n_i),
		.tck_rise_o(tck_rise),
		.tck_fall_o(tck_fall),
		.tms_o(tms_s),
		.tdi_o(tdi_s),
		.trst_n_o(trst_n_s)
	);

	tap_ctrl u_tap (
		.clk(clk),
		.rst_i(rst_i),
		.tck_rise_i(tck_rise),
		.tms_i(tms_s),
		.tdi_i(tdi_s),
		.trst_n_i(trst_n_s),
		.state_o(tap_state),
		.ir_o(ir),
		.ir_tdo_o(ir_tdo),
		.capture_dr_o(capture_dr),
		.shift_dr_o(shift_dr),
		.update_dr_o(update_dr)
	);

	dr_scan #(
		.IDCODE(IDCODE)
	) u_dr (
		.clk(clk),
		.rst_i(rst_i),
		.tck_fall_i(tck_fall),
		.tdi_i(tdi_s),
		.state_i(tap_state),
		.ir_i(ir),
		.ir_tdo_i(ir_tdo),
		.capture_dr_i(capture_dr),
		.shift_dr_i(shift_dr),
		.update_dr_i(update_dr),
		.rd_data_i(rd_data),
		.tdo_o(tdo_o),
		.req_o(req),
		.we_o(we),
		.addr_o(addr),
		.wr_data_o(wr_data)
	);

	cfg_regfile #(
		.NUM_CFG(NUM_CFG),
		.NUM_STAT(NUM_STAT)
	) u_regs (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(req),
		.we_i(we),
		.addr_i(addr),
		.wr_data_i(wr_data),
		.status_i(status_i),
		.rd_data_o(rd_data),
		.cfg_o(cfg_o)
	);

endmodule

`default_nettype wire

//--- src/cfg_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module cfg_regfile #(
	parameter int NUM_CFG = 8,
	parameter int NUM_STAT = 2
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic req_i,
	input wire logic we_i,
	input wire debug_pkg::reg_addr_t addr_i,
	input wire debug_pkg::reg_data_t wr_data_i,
	input wire logic [NUM_STAT*debug_pkg::DATA_W-1:0] status_i,
	output debug_pkg::reg_data_t rd_data_o,
	output logic [NUM_CFG*debug_pkg::DATA_W-1:0] cfg_o
);
	import debug_pkg::*;

	localparam int CFG_IW = (NUM_CFG > 1) ? $clog2(NUM_CFG) : 1;
	localparam int STAT_IW = (NUM_STAT > 1) ? $clog2(NUM_STAT) : 1;

	logic [NUM_CFG-1:0][DATA_W-1:0] cfg_q;
	logic [NUM_STAT-1:0][DATA_W-1:0] stat_w;
	reg_addr_t cfg_off;
	reg_addr_t stat_off;
	logic cfg_hit;
	logic stat_hit;
	logic [CFG_IW-1:0] cfg_idx;
	logic [STAT_IW-1:0] stat_idx;

	assign stat_w = status_i;

	// Address map decode
	assign cfg_off = addr_i - CFG_BASE;
	assign stat_off = addr_i - STATUS_BASE;
	assign cfg_hit = (addr_i >= CFG_BASE) && (int'(cfg_off) < NUM_CFG);
	assign stat_hit = (addr_i >= STATUS_BASE) && (int'(stat_off) < NUM_STAT);
	assign cfg_idx = cfg_off[CFG_IW-1:0];
	assign stat_idx = stat_off[STAT_IW-1:0];

	// Status and unmapped writes are dropped
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cfg_q <= '0;
		end else if (req_i && we_i && cfg_hit) begin
			cfg_q[cfg_idx] <= wr_data_i;
		end
	end

	always_comb begin
		rd_data_o = '0;
		if (cfg_hit) begin
			rd_data_o = cfg_q[cfg_idx];
		end else if (stat_hit) begin
			rd_data_o = stat_w[stat_idx];
		end
	end

	assign cfg_o = cfg_q;

endmodule

`default_nettype wire

//--- src/dr_scan.sv
`timescale 1ns/100ps
`default_nettype none

module dr_scan #(
	parameter jtag_pkg::idcode_t IDCODE = 32'h1D4B_0E93
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_fall_i,
	input wire logic tdi_i,
	input wire jtag_pkg::tap_state_t state_i,
	input wire jtag_pkg::ir_t ir_i,
	input wire logic ir_tdo_i,
	input wire logic capture_dr_i,
	input wire logic shift_dr_i,
	input wire logic update_dr_i,
	input wire debug_pkg::reg_data_t rd_data_i,
	output logic tdo_o,
	output logic req_o,
	output logic we_o,
	output debug_pkg::reg_addr_t addr_o,
	output debug_pkg::reg_data_t wr_data_o
);
	import jtag_pkg::*;
	import debug_pkg::*;

	idcode_t idcode_sr;
	logic bypass_sr;
	dbg_dr_t dbg_sr;
	reg_addr_t addr_q;
	reg_addr_t scan_addr;
	logic sel_idcode;
	logic sel_dbg;
	logic chain_tdo;

	// Undefined codes fall through to BYPASS
	assign sel_idcode = (ir_i == INSTR_IDCODE);
	assign sel_dbg = (ir_i == INSTR_DBG);

	always_ff @(posedge clk) begin
		if (capture_dr_i) begin
			if (sel_idcode) begin
				idcode_sr <= IDCODE;
			end else if (sel_dbg) begin
				// Readback of the address set by the previous scan
				dbg_sr <= {rd_data_i, addr_q, 1'b0};
			end else begin
				bypass_sr <= 1'b0;
			end
		end else if (shift_dr_i) begin
			if (sel_idcode) begin
				idcode_sr <= {tdi_i, idcode_sr[IDCODE_LEN-1:1]};
			end else if (sel_dbg) begin
				dbg_sr <= {tdi_i, dbg_sr[DBG_DR_LEN-1:1]};
			end else begin
				bypass_sr <= tdi_i;
			end
		end
	end

	assign scan_addr = dbg_sr[DBG_ADDR_LSB +: ADDR_W];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			addr_q <= '0;
		end else if (req_o) begin
			addr_q <= scan_addr;
		end
	end

	// Register file sees the scanned address during the request,
	// the latched one otherwise
	assign req_o = update_dr_i && sel_dbg;
	assign we_o = dbg_sr[DBG_WE_BIT];
	assign addr_o = req_o ? scan_addr : addr_q;
	assign wr_data_o = dbg_sr[DBG_DATA_LSB +: DATA_W];

	always_comb begin
		if (sel_idcode) begin
			chain_tdo = idcode_sr[0];
		end else if (sel_dbg) begin
			chain_tdo = dbg_sr[0];
		end else begin
			chain_tdo = bypass_sr;
		end
	end

	// TDO moves on the falling TCK edge, low outside the shift states
	always_ff @(posedge clk) begin
		if (rst_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			if (state_i == TAP_SHIFT_IR) begin
				tdo_o <= ir_tdo_i;
			end else if (state_i == TAP_SHIFT_DR) begin
				tdo_o <= chain_tdo;
			end else begin
				tdo_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/tap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tap_ctrl (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_rise_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output jtag_pkg::tap_state_t state_o,
	output jtag_pkg::ir_t ir_o,
	output logic ir_tdo_o,
	output logic capture_dr_o,
	output logic shift_dr_o,
	output logic update_dr_o
);
	import jtag_pkg::*;

	tap_state_t state_q;
	tap_state_t state_d;
	ir_t ir_sr;
	ir_t ir_q;
	logic tap_rst;

	assign tap_rst = rst_i || !trst_n_i;

	always_comb begin
		unique case (state_q)
			TAP_RESET: state_d = tms_i ? TAP_RESET : TAP_IDLE;
			TAP_IDLE: state_d = tms_i ? TAP_SEL_DR : TAP_IDLE;
			TAP_SEL_DR: state_d = tms_i ? TAP_SEL_IR : TAP_CAP_DR;
			TAP_CAP_DR: state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR: state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR: state_d = tms_i ? TAP_UPD_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR: state_d = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR: state_d = tms_i ? TAP_UPD_DR : TAP_SHIFT_DR;
			TAP_UPD_DR: state_d = tms_i ? TAP_SEL_DR : TAP_IDLE;
			TAP_SEL_IR: state_d = tms_i ? TAP_RESET : TAP_CAP_IR;
			TAP_CAP_IR: state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR: state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR: state_d = tms_i ? TAP_UPD_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR: state_d = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR: state_d = tms_i ? TAP_UPD_IR : TAP_SHIFT_IR;
			TAP_UPD_IR: state_d = tms_i ? TAP_SEL_DR : TAP_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (tap_rst) begin
			state_q <= TAP_RESET;
		end else if (tck_rise_i) begin
			state_q <= state_d;
		end
	end

	// IR shifter, LSB out first
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (state_q == TAP_CAP_IR) begin
				ir_sr <= IR_CAPTURE;
			end else if (state_q == TAP_SHIFT_IR) begin
				ir_sr <= {tdi_i, ir_sr[IR_LEN-1:1]};
			end
		end
	end

	// New instruction takes effect on entry to Update-IR
	always_ff @(posedge clk) begin
		if (tap_rst || state_q == TAP_RESET) begin
			ir_q <= INSTR_IDCODE;
		end else if (tck_rise_i && state_d == TAP_UPD_IR) begin
			ir_q <= ir_sr;
		end
	end

	// Capture and shift act on the TCK rise leaving the state,
	// update fires as Update-DR is entered
	always_ff @(posedge clk) begin
		if (tap_rst) begin
			capture_dr_o <= 1'b0;
			shift_dr_o <= 1'b0;
			update_dr_o <= 1'b0;
		end else begin
			capture_dr_o <= tck_rise_i && (state_q == TAP_CAP_DR);
			shift_dr_o <= tck_rise_i && (state_q == TAP_SHIFT_DR);
			update_dr_o <= tck_rise_i && (state_d == TAP_UPD_DR);
		end
	end

	assign state_o = state_q;
	assign ir_o = ir_q;
	assign ir_tdo_o = ir_sr[0];

endmodule

`default_nettype wire

//--- src/jtag_sync.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_sync (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic tck_i,
	input wire logic tms_i,
	input wire logic tdi_i,
	input wire logic trst_n_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_n_o
);
	localparam int P_TCK = 0;
	localparam int P_TMS = 1;
	localparam int P_TDI = 2;
	localparam int P_TRST = 3;

	// trst_n and tms idle high
	localparam logic [3:0] PIN_IDLE = 4'b1010;

	logic [3:0] pins_meta;
	logic [3:0] pins_sync;
	logic tck_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pins_meta <= PIN_IDLE;
			pins_sync <= PIN_IDLE;
			tck_q <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
		end else begin
			pins_meta <= {trst_n_i, tdi_i, tms_i, tck_i};
			pins_sync <= pins_meta;
			tck_q <= pins_sync[P_TCK];
			// One clk pulse per TCK edge
			tck_rise_o <= pins_sync[P_TCK] & ~tck_q;
			tck_fall_o <= ~pins_sync[P_TCK] & tck_q;
		end
	end

	assign tms_o = pins_sync[P_TMS];
	assign tdi_o = pins_sync[P_TDI];
	assign trst_n_o = pins_sync[P_TRST];

endmodule

`default_nettype wire

//--- src/debug_pkg.sv
package debug_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 16;

	typedef logic [ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] reg_data_t;

	// Debug chain holds write bit, address and data from the LSB up
	localparam int DBG_WE_BIT = 0;
	localparam int DBG_ADDR_LSB = 1;
	localparam int DBG_DATA_LSB = DBG_ADDR_LSB + ADDR_W;
	localparam int DBG_DR_LEN = DBG_DATA_LSB + DATA_W;

	typedef logic [DBG_DR_LEN-1:0] dbg_dr_t;

	// Config registers start at address 0
	localparam reg_addr_t CFG_BASE = 8'h00;

	// Status words sit from here upward
	localparam reg_addr_t STATUS_BASE = 8'h80;

endpackage

//--- src/jtag_pkg.sv
package jtag_pkg;

	// IEEE 1149.1 TAP controller states
	typedef enum logic [3:0] {
		TAP_RESET,
		TAP_IDLE,
		TAP_SEL_DR,
		TAP_CAP_DR,
		TAP_SHIFT_DR,
		TAP_EXIT1_DR,
		TAP_PAUSE_DR,
		TAP_EXIT2_DR,
		TAP_UPD_DR,
		TAP_SEL_IR,
		TAP_CAP_IR,
		TAP_SHIFT_IR,
		TAP_EXIT1_IR,
		TAP_PAUSE_IR,
		TAP_EXIT2_IR,
		TAP_UPD_IR
	} tap_state_t;

	localparam int IR_LEN = 4;

	typedef logic [IR_LEN-1:0] ir_t;

	// Instruction codes, anything not listed behaves as BYPASS
	localparam ir_t INSTR_IDCODE = 4'b0001;
	localparam ir_t INSTR_DBG = 4'b1000;
	localparam ir_t INSTR_BYPASS = 4'b1111;

	// Loaded into the IR shifter in Capture-IR, low bits 01 as the standard asks
	localparam ir_t IR_CAPTURE = 4'b0101;

	localparam int IDCODE_LEN = 32;

	typedef logic [IDCODE_LEN-1:0] idcode_t;

endpackage
